// File: verilog.f
+incdir+logic
logic/nccPkg.sv
logic/logConvert.sv
logic/antilogConvert.sv
logic/processingElement.sv
logic/scoreUnit.sv
logic/bestMatch.sv
logic/nccMatcher.sv
test/nccMatcher_checker.sv
test/nccMonitor.sv
test/nccMatcher_tb.sv

// File: test/nccMatcher_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ncc_defs.svh"

module nccMatcher_tb import nccPkg::*; ();

	localparam int numPix = `PATCH_DIM * `PATCH_DIM;
	localparam int rowBits = `PATCH_DIM * `PIXEL_W;
	localparam int winBits = numPix * `PIXEL_W;

	logic clk = 1'b0;
	logic rst;
	logic descValid;
	logic [rowBits-1:0] descWord;
	logic winValid;
	logic [winBits-1:0] winPixels;
	logic winDone;
	magLog_t bestScore;
	winIndex_t bestIndex;

	integer seed;
	logic [winBits-1:0] descImage, pix;

	always #50 clk = ~clk;

	nccMatcher uut (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descWord(descWord),
		.winValid(winValid),
		.winPixels(winPixels),
		.winDone(winDone),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

	nccMonitor mon (
		.clk(clk),
		.rst(rst),
		.descValid(descValid),
		.descWord(descWord),
		.winValid(winValid),
		.winPixels(winPixels),
		.winDone(winDone),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

	// one row per word with words back to back
	task automatic loadDescriptor();
		logic [rowBits-1:0] word;
		for (int r = 0; r < `PATCH_DIM; r++) begin
			for (int c = 0; c < `PATCH_DIM; c++) begin
				word[c*`PIXEL_W +: `PIXEL_W] = $random(seed);
			end
			descImage[(`PATCH_DIM-1-r)*rowBits +: rowBits] = word;
			@(posedge clk);
			descValid <= 1'b1;
			descWord <= word;
		end
		@(posedge clk);
		descValid <= 1'b0;
	endtask

	task automatic randomWindow(output logic [winBits-1:0] img);
		for (int k = 0; k < numPix; k++) begin
			img[k*`PIXEL_W +: `PIXEL_W] = $random(seed);
		end
	endtask

	// extra keeps the strobe up through WIN_LOAD with other pixels
	task automatic sendWindow(input logic [winBits-1:0] img, input logic extra);
		int waitCycles;
		@(posedge clk);
		winValid <= 1'b1;
		winPixels <= img;
		@(posedge clk);
		winValid <= extra;
		if (extra) begin
			winPixels <= ~img;
		end
		waitCycles = 0;
		@(negedge clk);
		while (winDone !== 1'b1 && waitCycles < 20) begin
			@(negedge clk);
			waitCycles++;
		end
		if (winDone !== 1'b1) begin
			mon.timeoutSeen("no winDone after a window strobe");
		end
		if (extra) begin
			@(posedge clk);
			winValid <= 1'b0;
		end
	endtask

	// lets the last best pair be compared
	task automatic drain();
		repeat (2) @(negedge clk);
		@(posedge clk);
	endtask

	initial begin
		seed = 32'hfeb7_b2e8;
		rst = 1'b1;
		descValid = 1'b0;
		descWord = '0;
		winValid = 1'b0;
		winPixels = '0;
		descImage = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		mon.checkReset();
		mon.finishTest("reset state");

		loadDescriptor();
		for (int i = 0; i < 10; i++) begin
			randomWindow(pix);
			sendWindow(pix, 1'b0);
		end
		drain();
		mon.finishTest("random windows");

		sendWindow(descImage, 1'b0);
		sendWindow(descImage, 1'b0);
		drain();
		mon.finishTest("window equal to descriptor");

		sendWindow('0, 1'b0);
		drain();
		mon.finishTest("all-zero window");

		randomWindow(pix);
		sendWindow(pix, 1'b1);
		drain();
		mon.finishTest("strobe during load");

		for (int i = 0; i < 152; i++) begin
			if (i == 76) begin
				loadDescriptor();
			end
			randomWindow(pix);
			sendWindow(pix, 1'b0);
		end
		drain();
		mon.finishTest("index wrap and reload");

		mon.report();
		if (mon.errorCount == 0 && uut.check.failCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: test/nccMonitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "ncc_defs.svh"

module nccMonitor import nccPkg::*; (
	input logic clk,
	input logic rst,
	input logic descValid,
	input logic [`PATCH_DIM*`PIXEL_W-1:0] descWord,
	input logic winValid,
	input logic [`PATCH_DIM*`PATCH_DIM*`PIXEL_W-1:0] winPixels,
	input logic winDone,
	input magLog_t bestScore,
	input winIndex_t bestIndex
);

	localparam int numPix = `PATCH_DIM * `PATCH_DIM;
	localparam int rowBits = `PATCH_DIM * `PIXEL_W;
	localparam int winBits = numPix * `PIXEL_W;

	logic [winBits-1:0] descFlat, pendingWin;
	int descRow;
	logic modelLoad, comparePending;
	magLog_t modelScore, newScore;
	winIndex_t modelIndex, modelCount;
	int checkCount = 0;
	int errorCount = 0;
	int testChecks = 0;
	int testErrors = 0;
	int windowCount = 0;

	// integer part is the leading one position
	// bits below it are left-aligned in the fraction
	function automatic logCode_t toLog(input acc_t v);
		int p;
		acc_t norm;
		p = 0;
		for (int i = 0; i < 32; i++) begin
			if (v[i]) begin
				p = i;
			end
		end
		if (v == 0) begin
			return '0;
		end
		norm = v << (31 - p);
		return {v[31], 5'(p), norm[30 -: `FRAC_W]};
	endfunction

	function automatic acc_t fromLog(input magLog_t code);
		int p;
		acc_t v;
		p = code[`FRAC_W+4 -: 5];
		v = 32'd1 << p;
		for (int b = 1; b <= p && b <= `FRAC_W; b++) begin
			v[p-b] = code[`FRAC_W-b];
		end
		return v;
	endfunction

	function automatic magLog_t refScore(input logic [winBits-1:0] desc,
			input logic [winBits-1:0] win);
		acc_t numSum, descSum, winSum, prod;
		logCode_t dCode, wCode, numCode, dSumCode, wSumCode;
		logic [32:0] pair;
		magLog_t numMag, denom, diff;
		numSum = '0;
		descSum = '0;
		winSum = '0;
		for (int k = 0; k < numPix; k++) begin
			dCode = toLog(acc_t'(desc[(numPix-1-k)*`PIXEL_W +: `PIXEL_W]));
			wCode = toLog(acc_t'(win[(numPix-1-k)*`PIXEL_W +: `PIXEL_W]));
			prod = fromLog(dCode[31:0] + wCode[31:0]);
			numSum = (dCode[32] ^ wCode[32]) ? numSum - prod : numSum + prod;
			descSum = descSum + fromLog(dCode[31:0] << 1);
			winSum = winSum + fromLog(wCode[31:0] << 1);
		end
		numCode = toLog(numSum);
		dSumCode = toLog(descSum);
		wSumCode = toLog(winSum);
		numMag = numCode[31:0];
		pair = {1'b0, dSumCode[31:0]} + {1'b0, wSumCode[31:0]};
		denom = pair[32:1];
		diff = numMag - denom;
		// wrapped subtraction is clamped
		return (diff > numMag) ? magLog_t'(1) : diff;
	endfunction

	task automatic countCheck(input logic bad);
		checkCount++;
		testChecks++;
		if (bad) begin
			errorCount++;
			testErrors++;
		end
	endtask

	always @(negedge clk) begin
		if (rst) begin
			descFlat = '0;
			pendingWin = '0;
			descRow = 0;
			modelLoad = 1'b0;
			comparePending = 1'b0;
			modelScore = '0;
			modelIndex = '0;
			modelCount = '0;
		end else begin
			// best pair was updated at the edge after winDone
			if (comparePending) begin
				comparePending = 1'b0;
				countCheck(bestScore !== modelScore || bestIndex !== modelIndex);
				if (bestScore !== modelScore || bestIndex !== modelIndex) begin
					$display("Fail at %0t: best %h at %0d, expected %h at %0d", $time,
						bestScore, bestIndex, modelScore, modelIndex);
				end
			end
			if (winDone !== modelLoad) begin
				countCheck(1'b1);
				$display("Fail at %0t: winDone %b, expected %b", $time, winDone, modelLoad);
			end
			if (modelLoad) begin
				newScore = refScore(descFlat, pendingWin);
				if (newScore > modelScore) begin
					modelScore = newScore;
					modelIndex = modelCount;
				end
				modelCount = (modelCount == `NUM_WINDOWS - 1) ? '0 : modelCount + 1'b1;
				windowCount++;
				comparePending = 1'b1;
				modelLoad = 1'b0;
			end else if (winValid) begin
				pendingWin = winPixels;
				modelLoad = 1'b1;
			end
			// descriptor row is written at the coming edge
			if (descValid) begin
				descFlat[(`PATCH_DIM-1-descRow)*rowBits +: rowBits] = descWord;
				descRow = (descRow == `PATCH_DIM - 1) ? 0 : descRow + 1;
			end
		end
	end

	task automatic checkReset();
		countCheck(winDone !== 1'b0 || bestScore !== '0 || bestIndex !== '0);
		if (winDone !== 1'b0 || bestScore !== '0 || bestIndex !== '0) begin
			$display("Fail at %0t: after reset winDone %b, best %h at %0d", $time,
				winDone, bestScore, bestIndex);
		end
	endtask

	task automatic timeoutSeen(input string what);
		countCheck(1'b1);
		$display("Timed out at %0t: %s", $time, what);
	endtask

	task automatic finishTest(input string name);
		$display("%s: %0d checks, %0d errors", name, testChecks, testErrors);
		testChecks = 0;
		testErrors = 0;
	endtask

	task automatic report();
		$display("Total: %0d windows, %0d checks, %0d errors", windowCount, checkCount,
			errorCount);
	endtask

endmodule

`default_nettype wire

// File: test/nccMatcher_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ncc_defs.svh"

module nccMatcher_checker import nccPkg::*; (
	input logic clk,
	input logic rst,
	input logic winValid,
	input logic winDone,
	input magLog_t bestScore
);

	int failCount = 0;

	// a strobe is accepted when no winDone is showing
	doneFollowsStrobe: assert property (@(posedge clk) disable iff (rst)
		(winValid && !winDone) |=> winDone)
	else begin
		failCount++;
		$error("winDone did not follow an accepted winValid");
	end

	doneSingleCycle: assert property (@(posedge clk) disable iff (rst)
		winDone |=> !winDone)
	else begin
		failCount++;
		$error("winDone stayed high for two cycles");
	end

	scoreNeverFalls: assert property (@(posedge clk) disable iff (rst)
		bestScore >= $past(bestScore))
	else begin
		failCount++;
		$error("bestScore decreased without reset");
	end

endmodule

bind nccMatcher nccMatcher_checker check (
	.clk(clk),
	.rst(rst),
	.winValid(winValid),
	.winDone(winDone),
	.bestScore(bestScore)
);

`default_nettype wire

// File: logic/nccMatcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "ncc_defs.svh"

module nccMatcher import nccPkg::*; (
	input logic clk,
	input logic rst,
	input logic descValid,
	input logic [`PATCH_DIM*`PIXEL_W-1:0] descWord,
	input logic winValid,
	input logic [`PATCH_DIM*`PATCH_DIM*`PIXEL_W-1:0] winPixels,
	output logic winDone,
	output magLog_t bestScore,
	output winIndex_t bestIndex
);

	localparam int rowW = (`PATCH_DIM > 1) ? $clog2(`PATCH_DIM) : 1;
	localparam int numPe = `PATCH_DIM * `PATCH_DIM;
	localparam int accW = $bits(acc_t);

	descState_t descState, descNext;
	winState_t winState, winNext;
	logic [rowW-1:0] descRow, rowSel;
	logic lastRow;
	logic winLoad;
	logCode_t descCode [`PATCH_DIM];
	acc_t chain [`PATCH_DIM][`PATCH_DIM+1];
	logic [`PATCH_DIM*accW-1:0] rowTotals;
	logic [numPe*accW-1:0] descSqs, winSqs;
	magLog_t score;

	// descriptor loader stays in DESC_LOAD while a descriptor is partly written
	assign lastRow = (descRow == rowW'(`PATCH_DIM - 1));
	assign rowSel = (descState == DESC_IDLE) ? '0 : descRow;

	always_comb begin
		descNext = descState;
		case (descState)
			DESC_IDLE: begin
				if (descValid && !lastRow) begin
					descNext = DESC_LOAD;
				end
			end
			DESC_LOAD: begin
				if (descValid && lastRow) begin
					descNext = DESC_IDLE;
				end
			end
			default: descNext = DESC_IDLE;
		endcase
	end

	// window loader samples the score the cycle after the load
	always_comb begin
		winNext = winState;
		winLoad = 1'b0;
		winDone = 1'b0;
		case (winState)
			WIN_WAIT: begin
				if (winValid) begin
					winLoad = 1'b1;
					winNext = WIN_LOAD;
				end
			end
			WIN_LOAD: begin
				winDone = 1'b1;
				winNext = WIN_WAIT;
			end
			default: winNext = WIN_WAIT;
		endcase
	end

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			descState <= DESC_IDLE;
			winState <= WIN_WAIT;
			descRow <= '0;
		end else begin
			descState <= descNext;
			winState <= winNext;
			if (descValid) begin
				descRow <= lastRow ? '0 : rowSel + 1'b1;
			end
		end
	end

	// most significant pixel of the descriptor word is column 0
	for (genvar c = 0; c < `PATCH_DIM; c++) begin : gDescConv
		pixel_t pixel;
		assign pixel = descWord[(`PATCH_DIM-1-c)*`PIXEL_W +: `PIXEL_W];
		logConvert descConv (.value(acc_t'(pixel)), .code(descCode[c]));
	end

	for (genvar r = 0; r < `PATCH_DIM; r++) begin : gRow
		logic rowLoad;

		assign rowLoad = descValid && (rowSel == rowW'(r));
		// each row chain starts from zero
		assign chain[r][0] = '0;
		assign rowTotals[r*accW +: accW] = chain[r][`PATCH_DIM];

		for (genvar c = 0; c < `PATCH_DIM; c++) begin : gCol
			localparam int k = r * `PATCH_DIM + c;
			pixel_t pixel;
			logCode_t winCode;

			// row-major window pixels with the first one in the top bits
			assign pixel = winPixels[(numPe-1-k)*`PIXEL_W +: `PIXEL_W];
			logConvert winConv (.value(acc_t'(pixel)), .code(winCode));

			processingElement pe (
				.clk(clk),
				.rst(rst),
				.descLoad(rowLoad),
				.winLoad(winLoad),
				.descIn(descCode[c]),
				.winIn(winCode),
				.accIn(chain[r][c]),
				.accOut(chain[r][c+1]),
				.descSq(descSqs[k*accW +: accW]),
				.winSq(winSqs[k*accW +: accW])
			);
		end
	end

	scoreUnit scorer (
		.rowTotals(rowTotals),
		.descSqs(descSqs),
		.winSqs(winSqs),
		.score(score)
	);

	bestMatch tracker (
		.clk(clk),
		.rst(rst),
		.sample(winDone),
		.score(score),
		.bestScore(bestScore),
		.bestIndex(bestIndex)
	);

endmodule

`default_nettype wire

// File: logic/bestMatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "ncc_defs.svh"

module bestMatch import nccPkg::*; (
	input logic clk,
	input logic rst,
	input logic sample,
	input magLog_t score,
	output magLog_t bestScore,
	output winIndex_t bestIndex
);

	winIndex_t winCount;
	logic lastWindow;

	assign lastWindow = (winCount == winIndex_t'(`NUM_WINDOWS - 1));

	// index of the window being sampled
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			winCount <= '0;
		end else if (sample) begin
			winCount <= lastWindow ? '0 : winCount + 1'b1;
		end
	end

	// only a strictly greater score replaces the stored pair
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			bestScore <= '0;
			bestIndex <= '0;
		end else if (sample && (score > bestScore)) begin
			bestScore <= score;
			bestIndex <= winCount;
		end
	end

endmodule

`default_nettype wire

// File: logic/scoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ncc_defs.svh"

module scoreUnit import nccPkg::*; (
	input logic [`PATCH_DIM*32-1:0] rowTotals,
	input logic [`PATCH_DIM*`PATCH_DIM*32-1:0] descSqs,
	input logic [`PATCH_DIM*`PATCH_DIM*32-1:0] winSqs,
	output magLog_t score
);

	localparam int numPe = `PATCH_DIM * `PATCH_DIM;
	localparam int accW = $bits(acc_t);
	localparam int magW = $bits(magLog_t);

	acc_t numSum, descSum, winSum;
	logCode_t numLog, descLog, winLog;
	logic [magW:0] denomSum;
	magLog_t denom, diff;

	// numerator adds all row chains together
	always_comb begin
		numSum = '0;
		for (int r = 0; r < `PATCH_DIM; r++) begin
			numSum = numSum + rowTotals[r*accW +: accW];
		end
	end

	always_comb begin
		descSum = '0;
		winSum = '0;
		for (int k = 0; k < numPe; k++) begin
			descSum = descSum + descSqs[k*accW +: accW];
			winSum = winSum + winSqs[k*accW +: accW];
		end
	end

	logConvert numConv (.value(numSum), .code(numLog));
	logConvert descConv (.value(descSum), .code(descLog));
	logConvert winConv (.value(winSum), .code(winLog));

	// square root of the product is half the summed logs
	assign denomSum = {1'b0, descLog[magW-1:0]} + {1'b0, winLog[magW-1:0]};
	assign denom = denomSum[magW:1];

	assign diff = numLog[magW-1:0] - denom;

	// a wrapped subtraction lands above the numerator
	// such a result is clamped to 1
	assign score = (diff > numLog[magW-1:0]) ? magLog_t'(1) : diff;

endmodule

`default_nettype wire

// File: logic/processingElement.sv
`timescale 1ns/1ps
`default_nettype none

`include "ncc_defs.svh"

module processingElement import nccPkg::*; (
	input logic clk,
	input logic rst,
	input logic descLoad,
	input logic winLoad,
	input logCode_t descIn,
	input logCode_t winIn,
	input acc_t accIn,
	output acc_t accOut,
	output acc_t descSq,
	output acc_t winSq
);

	logCode_t descCode, winCode;
	magLog_t prodLog, descSqLog, winSqLog;
	acc_t product;
	logic negative;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			descCode <= '0;
			winCode <= '0;
		end else begin
			if (descLoad) begin
				descCode <= descIn;
			end
			if (winLoad) begin
				winCode <= winIn;
			end
		end
	end

	// product in log domain is the sum of magnitudes
	assign prodLog = descCode[`FRAC_W+4:0] + winCode[`FRAC_W+4:0];
	assign negative = descCode[`FRAC_W+5] ^ winCode[`FRAC_W+5];

	// squares for the denominator use twice the code
	assign descSqLog = descCode[`FRAC_W+4:0] << 1;
	assign winSqLog = winCode[`FRAC_W+4:0] << 1;

	antilogConvert prodConv (.code(prodLog), .value(product));
	antilogConvert descSqConv (.code(descSqLog), .value(descSq));
	antilogConvert winSqConv (.code(winSqLog), .value(winSq));

	assign accOut = negative ? (accIn - product) : (accIn + product);

endmodule

`default_nettype wire

// File: logic/antilogConvert.sv
`timescale 1ns/1ps
`default_nettype none

`include "ncc_defs.svh"

module antilogConvert import nccPkg::*; (
	input magLog_t code,
	output acc_t value
);

	logic [4:0] position;
	logic [`FRAC_W-1:0] fraction;
	logic [63:0] mantissa;
	logic [63:0] shifted;

	assign position = code[`FRAC_W+4:`FRAC_W];
	assign fraction = code[`FRAC_W-1:0];

	// restore the implicit one just above the fraction
	assign mantissa = {{(63 - `FRAC_W){1'b0}}, 1'b1, fraction};
	assign shifted = mantissa << position;

	// integer part starts where the fraction used to begin
	// fraction bits that land below bit zero are dropped
	assign value = shifted[`FRAC_W+31:`FRAC_W];

endmodule

`default_nettype wire

// File: logic/logConvert.sv
`timescale 1ns/1ps
`default_nettype none

`include "ncc_defs.svh"

module logConvert import nccPkg::*; (
	input acc_t value,
	output logCode_t code
);

	// leading zero count, one bit per narrowing stage
	logic [4:0] lz;
	acc_t s16, s8, s4, s2, s1;

	// each stage checks the upper half of what is left and shifts it up if empty
	always_comb begin
		lz[4] = (value[31:16] == '0);
		s16 = lz[4] ? {value[15:0], 16'b0} : value;
		lz[3] = (s16[31:24] == '0);
		s8 = lz[3] ? {s16[23:0], 8'b0} : s16;
		lz[2] = (s8[31:28] == '0);
		s4 = lz[2] ? {s8[27:0], 4'b0} : s8;
		lz[1] = (s4[31:30] == '0);
		s2 = lz[1] ? {s4[29:0], 2'b0} : s4;
		lz[0] = ~s2[31];
		s1 = lz[0] ? {s2[30:0], 1'b0} : s2;
	end

	// leading one now sits at bit 31
	// fraction is what follows it
	// zero input ends with lz = 31 and s1 = 0, so the code is all zero
	assign code = {value[31], ~lz, s1[30 -: `FRAC_W]};

endmodule

`default_nettype wire

// File: logic/nccPkg.sv
`default_nettype none

`include "ncc_defs.svh"

package nccPkg;

	// sign bit, 5-bit leading-one position, fraction
	typedef logic [`FRAC_W+5:0] logCode_t;
	// log code with the sign dropped, used for scores
	typedef logic [`FRAC_W+4:0] magLog_t;
	typedef logic [`PIXEL_W-1:0] pixel_t;
	typedef logic [31:0] acc_t;
	typedef logic [`IDX_W-1:0] winIndex_t;

	typedef enum logic {
		DESC_IDLE,
		DESC_LOAD
	} descState_t;

	typedef enum logic {
		WIN_WAIT,
		WIN_LOAD
	} winState_t;

endpackage

`default_nettype wire

// File: logic/ncc_defs.svh
`ifndef NCC_DEFS_SVH
`define NCC_DEFS_SVH

// pixels per patch side
// one descriptor word carries one full row
`define PATCH_DIM 4

// bits per pixel
`define PIXEL_W 8

// fraction bits below the leading one in a log code
`define FRAC_W 27

// windows per search frame; the index wraps after this many
`define NUM_WINDOWS 150

// width of the window index
`define IDX_W 9

`endif
